//--- rtl/pipeCpu_config.svh
`ifndef PIPECPU_CONFIG_SVH
`define PIPECPU_CONFIG_SVH

// Datapath sizes
`define WORD_W       16
`define REG_ADDR_W   4
`define IMEM_ADDR_W  8   // Low bits of pc
`define DMEM_ADDR_W  8   // Low bits of the ALU address

// Opcodes, instr[15:12]
`define OP_ADD  4'd0
`define OP_SUB  4'd1
`define OP_AND  4'd2
`define OP_NOR  4'd3
`define OP_SLL  4'd4
`define OP_SRL  4'd5
`define OP_SRA  4'd6
`define OP_LW   4'd8
`define OP_SW   4'd9
`define OP_LLB  4'd10
`define OP_HLT  4'd15   // Unlisted codes decode as NOP

`endif

//--- rtl/pipeCpuPkg.sv
`include "pipeCpu_config.svh"

package pipeCpuPkg;

  typedef logic [`WORD_W-1:0]      word_t;      // Data or instruction
  typedef logic [`REG_ADDR_W-1:0]  regAddr_t;   // Register index
  typedef logic [`IMEM_ADDR_W-1:0] imemAddr_t;
  typedef logic [`DMEM_ADDR_W-1:0] dmemAddr_t;

  typedef enum logic [3:0] {
    OP_ADD = `OP_ADD,
    OP_SUB = `OP_SUB,
    OP_AND = `OP_AND,
    OP_NOR = `OP_NOR,
    OP_SLL = `OP_SLL,
    OP_SRL = `OP_SRL,
    OP_SRA = `OP_SRA,
    OP_LW  = `OP_LW,
    OP_SW  = `OP_SW,
    OP_LLB = `OP_LLB,
    OP_HLT = `OP_HLT
  } opcode_t;

  // ALU operand source in execute
  typedef enum logic [1:0] {FWD_NONE, FWD_DM, FWD_WB} fwdSel_t;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_NOR,
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_PASSB   // Operand B straight through
  } aluOp_t;

endpackage

//--- rtl/regFile.sv
`timescale 1ns/100ps
`include "pipeCpu_config.svh"

module regFile (
  input  logic                 clk,
  input  logic                 rstN,
  input  pipeCpuPkg::regAddr_t rdAddrA,
  input  pipeCpuPkg::regAddr_t rdAddrB,
  input  logic                 wrEn,
  input  pipeCpuPkg::regAddr_t wrAddr,
  input  pipeCpuPkg::word_t    wrData,
  output pipeCpuPkg::word_t    rdDataA,
  output pipeCpuPkg::word_t    rdDataB
);
  import pipeCpuPkg::*;

  word_t regs [0:(1 << `REG_ADDR_W)-1];

  // R0 never written
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < (1 << `REG_ADDR_W); i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && wrAddr != '0) begin
      regs[wrAddr] <= wrData;
    end
  end

  // R0 reads zero, same-cycle write passes through
  assign rdDataA = (rdAddrA == '0)                  ? '0     :
                   (wrEn && wrAddr == rdAddrA)      ? wrData :
                                                      regs[rdAddrA];
  assign rdDataB = (rdAddrB == '0)                  ? '0     :
                   (wrEn && wrAddr == rdAddrB)      ? wrData :
                                                      regs[rdAddrB];

endmodule

//--- rtl/fetchStage.sv
`timescale 1ns/100ps
`include "pipeCpu_config.svh"

module fetchStage (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  imemWrEn,
  input  pipeCpuPkg::imemAddr_t imemWrAddr,
  input  pipeCpuPkg::word_t     imemWrData,
  input  logic                  stall,      // Load-use hold
  input  logic                  drain,      // HLT decoded
  output pipeCpuPkg::word_t     pc,
  output pipeCpuPkg::word_t     ifIdInstr,
  output logic                  ifIdValid
);
  import pipeCpuPkg::*;

  word_t     imem [0:(1 << `IMEM_ADDR_W)-1];
  imemAddr_t fetchAddr;
  word_t     fetchWord;

  ////////////////////////////////////////////////////////////
  // Instruction memory
  ////////////////////////////////////////////////////////////

  // Load port, used while the core sits in reset
  always_ff @(posedge clk) begin
    if (imemWrEn) begin
      imem[imemWrAddr] <= imemWrData;
    end
  end

  assign fetchAddr = pc[`IMEM_ADDR_W-1:0];   // Word addressed
  assign fetchWord = imem[fetchAddr];        // Async read

  ////////////////////////////////////////////////////////////
  // PC and IF/ID
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc        <= '0;
      ifIdInstr <= '0;
      ifIdValid <= 1'b0;
    end else if (!stall) begin               // Stall keeps pc and IF/ID
      if (drain) begin
        // pc frozen past HLT, feed bubbles
        ifIdInstr <= '0;
        ifIdValid <= 1'b0;
      end else begin
        pc        <= pc + word_t'(1);
        ifIdInstr <= fetchWord;
        ifIdValid <= 1'b1;
      end
    end
  end

  // Nothing to do in a stall cycle

endmodule

//--- rtl/decodeStage.sv
`timescale 1ns/100ps
`include "pipeCpu_config.svh"

module decodeStage (
  input  logic                 clk,
  input  logic                 rstN,
  input  pipeCpuPkg::word_t    ifIdInstr,
  input  logic                 ifIdValid,
  input  logic                 wbEn,
  input  pipeCpuPkg::regAddr_t wbAddr,
  input  pipeCpuPkg::word_t    wbData,
  output logic                 stall,
  output logic                 drain,
  output pipeCpuPkg::aluOp_t   idExAluOp,
  output logic                 idExRegWrite,
  output logic                 idExMemRead,
  output logic                 idExMemWrite,
  output logic                 idExHalt,
  output logic                 idExUseImm,
  output pipeCpuPkg::regAddr_t idExDest,
  output pipeCpuPkg::regAddr_t idExRs,
  output pipeCpuPkg::regAddr_t idExRt,
  output pipeCpuPkg::word_t    idExRsData,
  output pipeCpuPkg::word_t    idExRtData,
  output pipeCpuPkg::word_t    idExImm
);
  import pipeCpuPkg::*;

  opcode_t  opcode;
  regAddr_t rdField, rsField, rtField;
  regAddr_t rdAddrB;                          // Second read index
  word_t    rsData, rtData, immExt;
  aluOp_t   aluOp;
  logic     isRType, isShift, isLw, isSw, isLlb, isHlt;
  logic     regWrite, useImm, usesRs, usesRt;
  logic     hltInId, haltSeen, take;

  assign opcode  = opcode_t'(ifIdInstr[15:12]);
  assign rdField = ifIdInstr[11:8];
  assign rsField = ifIdInstr[7:4];
  assign rtField = ifIdInstr[3:0];

  ////////////////////////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////////////////////////
  assign isRType = opcode inside {OP_ADD, OP_SUB, OP_AND, OP_NOR};
  assign isShift = opcode inside {OP_SLL, OP_SRL, OP_SRA};
  assign isLw    = (opcode == OP_LW);
  assign isSw    = (opcode == OP_SW);
  assign isLlb   = (opcode == OP_LLB);
  assign isHlt   = (opcode == OP_HLT);

  always_comb begin
    case (opcode)
      OP_SUB:  aluOp = ALU_SUB;
      OP_AND:  aluOp = ALU_AND;
      OP_NOR:  aluOp = ALU_NOR;
      OP_SLL:  aluOp = ALU_SLL;
      OP_SRL:  aluOp = ALU_SRL;
      OP_SRA:  aluOp = ALU_SRA;
      OP_LLB:  aluOp = ALU_PASSB;
      default: aluOp = ALU_ADD;               // ADD, and base + offset for LW/SW
    endcase
  end

  assign regWrite = (isRType | isShift | isLw | isLlb) & (rdField != '0); // R0 dropped here
  assign useImm   = isLw | isSw | isLlb;
  assign usesRs   = isRType | isShift | isLw | isSw;
  assign usesRt   = isRType | isSw;           // Shifts take rt as amount
  assign rdAddrB  = isSw ? rdField : rtField; // SW stores rd

  // LLB takes 8 bits, memory offset 4 bits, both signed
  assign immExt = isLlb ? {{(`WORD_W-8){ifIdInstr[7]}}, ifIdInstr[7:0]}
                        : {{(`WORD_W-4){ifIdInstr[3]}}, ifIdInstr[3:0]};

  regFile uRegFile (
    .clk, .rstN,
    .rdAddrA(rsField), .rdAddrB(rdAddrB),
    .wrEn(wbEn), .wrAddr(wbAddr), .wrData(wbData),
    .rdDataA(rsData), .rdDataB(rtData)
  );

  ////////////////////////////////////////////////////////////
  // Load-use hazard and halt
  ////////////////////////////////////////////////////////////
  assign stall = ifIdValid && idExMemRead && (idExDest != '0) &&
                 ((usesRs && rsField == idExDest) || (usesRt && rdAddrB == idExDest));

  assign hltInId = ifIdValid && isHlt;       // HLT never stalls, reads nothing
  assign drain   = haltSeen || hltInId;
  assign take    = ifIdValid && !stall;      // Else a bubble goes to EX

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      haltSeen <= 1'b0;
    end else if (hltInId) begin
      haltSeen <= 1'b1;                      // Sticky until reset
    end
  end

  ////////////////////////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      idExAluOp    <= ALU_ADD;
      idExRegWrite <= 1'b0;
      idExMemRead  <= 1'b0;
      idExMemWrite <= 1'b0;
      idExHalt     <= 1'b0;
      idExUseImm   <= 1'b0;
      idExDest     <= '0;
    end else begin
      idExAluOp    <= aluOp;
      idExRegWrite <= take && regWrite;
      idExMemRead  <= take && isLw;
      idExMemWrite <= take && isSw;
      idExHalt     <= take && isHlt;
      idExUseImm   <= useImm;
      idExDest     <= rdField;
    end
  end

  // Operands, meaningless under a bubble
  always_ff @(posedge clk) begin
    idExRs     <= rsField;
    idExRt     <= rdAddrB;
    idExRsData <= rsData;
    idExRtData <= rtData;
    idExImm    <= immExt;
  end

endmodule

//--- rtl/executeStage.sv
`timescale 1ns/100ps

module executeStage (
  input  logic                 clk,
  input  logic                 rstN,
  input  pipeCpuPkg::aluOp_t   idExAluOp,
  input  logic                 idExRegWrite,
  input  logic                 idExMemRead,
  input  logic                 idExMemWrite,
  input  logic                 idExHalt,
  input  logic                 idExUseImm,
  input  pipeCpuPkg::regAddr_t idExDest,
  input  pipeCpuPkg::regAddr_t idExRs,
  input  pipeCpuPkg::regAddr_t idExRt,
  input  pipeCpuPkg::word_t    idExRsData,
  input  pipeCpuPkg::word_t    idExRtData,
  input  pipeCpuPkg::word_t    idExImm,
  input  logic                 wbEn,
  input  pipeCpuPkg::regAddr_t wbAddr,
  input  pipeCpuPkg::word_t    wbData,
  output pipeCpuPkg::word_t    exDmAluResult,
  output pipeCpuPkg::word_t    exDmStoreData,
  output pipeCpuPkg::regAddr_t exDmDest,
  output logic                 exDmRegWrite,
  output logic                 exDmMemRead,
  output logic                 exDmMemWrite,
  output logic                 exDmHalt
);
  import pipeCpuPkg::*;

  fwdSel_t fwdA, fwdB;
  word_t   opA, rtVal, opB, aluOut;

  ////////////////////////////////////////////////////////////
  // Forwarding
  ////////////////////////////////////////////////////////////

  // Younger EX/DM result wins over DM/WB; loads there are covered by the stall
  function automatic fwdSel_t pickSrc(input regAddr_t src);
    if (exDmRegWrite && !exDmMemRead && exDmDest != '0 && exDmDest == src) begin
      return FWD_DM;
    end else if (wbEn && wbAddr == src) begin
      return FWD_WB;
    end
    return FWD_NONE;
  endfunction

  function automatic word_t fwdMux(input fwdSel_t sel, input word_t regVal);
    case (sel)
      FWD_DM:  return exDmAluResult;
      FWD_WB:  return wbData;
      default: return regVal;
    endcase
  endfunction

  always_comb begin
    fwdA  = pickSrc(idExRs);
    fwdB  = pickSrc(idExRt);
    opA   = fwdMux(fwdA, idExRsData);
    rtVal = fwdMux(fwdB, idExRtData);       // Also the SW store data
    opB   = idExUseImm ? idExImm : rtVal;
  end

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (idExAluOp)
      ALU_ADD: aluOut = opA + opB;           // Wraps
      ALU_SUB: aluOut = opA - opB;
      ALU_AND: aluOut = opA & opB;
      ALU_NOR: aluOut = ~(opA | opB);
      ALU_SLL: aluOut = opA << idExRt;       // rt field is the amount
      ALU_SRL: aluOut = opA >> idExRt;
      ALU_SRA: aluOut = word_t'($signed(opA) >>> idExRt);
      default: aluOut = opB;                 // PASSB for LLB
    endcase
  end

  ////////////////////////////////////////////////////////////
  // EX/DM register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exDmDest     <= '0;
      exDmRegWrite <= 1'b0;
      exDmMemRead  <= 1'b0;
      exDmMemWrite <= 1'b0;
      exDmHalt     <= 1'b0;
    end else begin
      exDmDest     <= idExDest;
      exDmRegWrite <= idExRegWrite;
      exDmMemRead  <= idExMemRead;
      exDmMemWrite <= idExMemWrite;
      exDmHalt     <= idExHalt;
    end
  end

  always_ff @(posedge clk) begin
    exDmAluResult <= aluOut;                 // Result or memory address
    exDmStoreData <= rtVal;
  end

endmodule

//--- rtl/memoryStage.sv
`timescale 1ns/100ps
`include "pipeCpu_config.svh"

module memoryStage (
  input  logic                 clk,
  input  logic                 rstN,
  input  pipeCpuPkg::word_t    exDmAluResult,
  input  pipeCpuPkg::word_t    exDmStoreData,
  input  pipeCpuPkg::regAddr_t exDmDest,
  input  logic                 exDmRegWrite,
  input  logic                 exDmMemRead,
  input  logic                 exDmMemWrite,
  input  logic                 exDmHalt,
  output logic                 wbEn,
  output pipeCpuPkg::regAddr_t wbAddr,
  output pipeCpuPkg::word_t    wbData,
  output logic                 hlt
);
  import pipeCpuPkg::*;

  word_t     dmem [0:(1 << `DMEM_ADDR_W)-1];
  dmemAddr_t memAddr;
  word_t     loadData;

  ////////////////////////////////////////////////////////////
  // Data memory
  ////////////////////////////////////////////////////////////
  assign memAddr  = exDmAluResult[`DMEM_ADDR_W-1:0];   // Low address bits
  assign loadData = dmem[memAddr];                     // Async read

  always_ff @(posedge clk) begin
    if (exDmMemWrite) begin
      dmem[memAddr] <= exDmStoreData;
    end
  end

  ////////////////////////////////////////////////////////////
  // DM/WB register and halt flag
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wbEn   <= 1'b0;
      wbAddr <= '0;
      hlt    <= 1'b0;
    end else begin
      wbEn   <= exDmRegWrite;
      wbAddr <= exDmDest;
      hlt    <= hlt | exDmHalt;      // Stays up until reset
    end
  end

  always_ff @(posedge clk) begin
    wbData <= exDmMemRead ? loadData : exDmAluResult;
  end

endmodule

//--- rtl/pipeCpu.sv
`timescale 1ns/100ps

module pipeCpu (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  imemWrEn,    // Program load port
  input  pipeCpuPkg::imemAddr_t imemWrAddr,
  input  pipeCpuPkg::word_t     imemWrData,
  output pipeCpuPkg::word_t     pc,
  output logic                  hlt,
  output logic                  wbEn,        // Write-back observation
  output pipeCpuPkg::regAddr_t  wbAddr,
  output pipeCpuPkg::word_t     wbData
);
  import pipeCpuPkg::*;

  // IF/ID and hazard levels
  word_t    ifIdInstr;
  logic     ifIdValid;
  logic     stall, drain;

  // ID/EX
  aluOp_t   idExAluOp;
  logic     idExRegWrite, idExMemRead, idExMemWrite, idExHalt, idExUseImm;
  regAddr_t idExDest, idExRs, idExRt;
  word_t    idExRsData, idExRtData, idExImm;

  // EX/DM
  word_t    exDmAluResult, exDmStoreData;
  regAddr_t exDmDest;
  logic     exDmRegWrite, exDmMemRead, exDmMemWrite, exDmHalt;

  ////////////////////////////////////////////////////////////
  // Stage chain IF -> ID -> EX -> DM/WB
  ////////////////////////////////////////////////////////////
  fetchStage uFetch (
    .clk, .rstN,
    .imemWrEn, .imemWrAddr, .imemWrData,
    .stall, .drain,
    .pc, .ifIdInstr, .ifIdValid
  );

  decodeStage uDecode (
    .clk, .rstN,
    .ifIdInstr, .ifIdValid,
    .wbEn, .wbAddr, .wbData,           // Register-file write port
    .stall, .drain,
    .idExAluOp, .idExRegWrite, .idExMemRead, .idExMemWrite, .idExHalt, .idExUseImm,
    .idExDest, .idExRs, .idExRt,
    .idExRsData, .idExRtData, .idExImm
  );

  executeStage uExecute (
    .clk, .rstN,
    .idExAluOp, .idExRegWrite, .idExMemRead, .idExMemWrite, .idExHalt, .idExUseImm,
    .idExDest, .idExRs, .idExRt,
    .idExRsData, .idExRtData, .idExImm,
    .wbEn, .wbAddr, .wbData,           // Second forwarding source
    .exDmAluResult, .exDmStoreData, .exDmDest,
    .exDmRegWrite, .exDmMemRead, .exDmMemWrite, .exDmHalt
  );

  memoryStage uMemory (
    .clk, .rstN,
    .exDmAluResult, .exDmStoreData, .exDmDest,
    .exDmRegWrite, .exDmMemRead, .exDmMemWrite, .exDmHalt,
    .wbEn, .wbAddr, .wbData,
    .hlt
  );

endmodule

//--- verification/pipeCpu_properties.sv
`timescale 1ns/100ps

module pipeCpuProperties (
  input logic                 clk,
  input logic                 rstN,
  input pipeCpuPkg::word_t    pc,
  input logic                 hlt,
  input logic                 wbEn,
  input pipeCpuPkg::regAddr_t wbAddr
);
  import pipeCpuPkg::*;

  ////////////////////////////////////////////////////////////
  // Halt and write-back rules
  ////////////////////////////////////////////////////////////
  hltSticky: assert property (@(posedge clk) disable iff (!rstN) hlt |=> hlt)
    else $error("hlt fell while out of reset");

  // R0 writes are dropped in decode
  noR0Write: assert property (@(posedge clk) disable iff (!rstN) wbEn |-> wbAddr != '0)
    else $error("write-back to R0");

  pcFrozen: assert property (@(posedge clk) disable iff (!rstN) hlt |=> $stable(pc))
    else $error("pc moved after hlt");   // Fetch drained since HLT decode

endmodule

bind pipeCpu pipeCpuProperties uProps (.clk, .rstN, .pc, .hlt, .wbEn, .wbAddr);

//--- verification/pipeCpuTb.sv
`timescale 1ns/100ps

module pipeCpuTb;
  import pipeCpuPkg::*;

  localparam int ResetCycles = 5;
  localparam int HaltWatch   = 6;      // Cycles watched once hlt is up

  logic      clk, rstN, imemWrEn, hlt, wbEn;
  imemAddr_t imemWrAddr;
  word_t     imemWrData, pc, wbData, pcAtHalt;
  regAddr_t  wbAddr;

  // Program table, one row per instruction
  word_t    progQ[$];
  logic     expWrQ[$];                 // Row writes back
  regAddr_t expDestQ[$];
  word_t    expValQ[$];
  string    testQ[$];                  // Behavior the row belongs to

  int checkCount = 0;
  int errCount   = 0;
  int errMark    = 0;                  // errCount when the current test began
  int hltRow;

  pipeCpu dut (
    .clk, .rstN, .imemWrEn, .imemWrAddr, .imemWrData,
    .pc, .hlt, .wbEn, .wbAddr, .wbData
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;            // 100 ns period
  end

  ////////////////////////////////////////////////////////////
  // Instruction encoding and table
  ////////////////////////////////////////////////////////////
  function automatic word_t encodeR(input opcode_t op, input int rd, input int rs, input int rt);
    return {op, rd[3:0], rs[3:0], rt[3:0]};   // rt doubles as shift amount or offset
  endfunction

  function automatic word_t encodeLlb(input int rd, input int imm);
    return {OP_LLB, rd[3:0], imm[7:0]};
  endfunction

  task automatic addRow(input string test, input word_t instr, input logic wr,
                        input int dest, input word_t val);
    testQ.push_back(test);
    progQ.push_back(instr);
    expWrQ.push_back(wr);
    expDestQ.push_back(regAddr_t'(dest));
    expValQ.push_back(val);
  endtask

  task automatic buildProgram();
    addRow("alu ops", encodeLlb(1, 'h35), 1'b1, 1, 16'h0035);
    addRow("alu ops", encodeLlb(2, 'h0F), 1'b1, 2, 16'h000F);
    addRow("alu ops", encodeLlb(3, 'hF0), 1'b1, 3, 16'hFFF0);          // Sign extended
    addRow("alu ops", encodeLlb(0, 'h77), 1'b0, 0, 16'h0000);          // R0 not written
    addRow("alu ops", encodeR(OP_ADD, 4, 1, 2), 1'b1, 4, 16'h0044);    // 35 + 0F
    addRow("alu ops", encodeR(OP_SUB, 5, 1, 2), 1'b1, 5, 16'h0026);
    addRow("alu ops", encodeR(OP_AND, 6, 1, 3), 1'b1, 6, 16'h0030);
    addRow("alu ops", encodeR(OP_NOR, 7, 1, 2), 1'b1, 7, 16'hFFC0);    // ~003F
    addRow("alu ops", encodeR(OP_SLL, 8, 1, 4), 1'b1, 8, 16'h0350);
    addRow("alu ops", encodeR(OP_SRL, 9, 3, 2), 1'b1, 9, 16'h3FFC);    // Zero fill
    addRow("alu ops", encodeR(OP_SRA, 10, 3, 2), 1'b1, 10, 16'hFFFC);  // Sign fill
    // Dependent chain, distance one and two
    addRow("forwarding", encodeR(OP_ADD, 11, 1, 1), 1'b1, 11, 16'h006A);
    addRow("forwarding", encodeR(OP_SUB, 12, 11, 2), 1'b1, 12, 16'h005B);
    addRow("forwarding", encodeR(OP_AND, 13, 11, 12), 1'b1, 13, 16'h004A);
    addRow("forwarding", encodeR(OP_SUB, 14, 2, 13), 1'b1, 14, 16'hFFC5);  // Wraps
    // Address 000F - 3 = 000C for both
    addRow("store load", encodeR(OP_SW, 5, 2, -3), 1'b0, 0, 16'h0000);
    addRow("store load", encodeR(OP_LW, 15, 2, -3), 1'b1, 15, 16'h0026);
    addRow("store load", encodeR(OP_ADD, 4, 15, 15), 1'b1, 4, 16'h004C);  // Load-use
    hltRow = progQ.size();
    addRow("halt", encodeR(OP_HLT, 0, 0, 0), 1'b0, 0, 16'h0000);
    addRow("halt", encodeLlb(1, 'h11), 1'b0, 0, 16'h0000);            // Past HLT, never written
    addRow("halt", encodeR(OP_ADD, 2, 1, 1), 1'b0, 0, 16'h0000);
  endtask

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  task automatic flagError(input string msg);
    errCount++;
    $display("error at %0d ns: %s", $time, msg);
  endtask

  task automatic checkIdle(input string where);
    checkCount++;
    if (pc !== '0 || hlt !== 1'b0 || wbEn !== 1'b0) begin
      flagError($sformatf("%s: pc %h hlt %b wbEn %b, expected all zero", where, pc, hlt, wbEn));
    end
  endtask

  task automatic checkWrite(input int row);
    checkCount++;
    if (wbAddr !== expDestQ[row] || wbData !== expValQ[row] || hlt !== 1'b0) begin
      flagError($sformatf("row %0d wrote R%0d = %h with hlt %b, expected R%0d = %h",
                          row, wbAddr, wbData, hlt, expDestQ[row], expValQ[row]));
    end
  endtask

  task automatic reportTest(input string name);
    $display("test %s: %0d errors", name, errCount - errMark);
    errMark = errCount;
  endtask

  initial begin
    rstN       <= 1'b0;
    imemWrEn   <= 1'b0;
    imemWrAddr <= '0;
    imemWrData <= '0;
    buildProgram();

    for (int i = 0; i < progQ.size(); i++) begin   // Program load while in reset
      @(posedge clk);
      imemWrEn   <= 1'b1;
      imemWrAddr <= imemAddr_t'(i);
      imemWrData <= progQ[i];
    end
    @(posedge clk);
    imemWrEn <= 1'b0;
    repeat (ResetCycles) begin
      @(negedge clk);
      checkIdle("during reset");
    end
    @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    checkIdle("after reset");                       // Before the first fetch edge
    reportTest("reset");

    // One wbEn pulse per writing row, in program order
    for (int i = 0; i < hltRow; i++) begin
      if (expWrQ[i]) begin
        do begin
          @(negedge clk);
        end while (!wbEn);
        checkWrite(i);
      end
      if (i == hltRow - 1 || testQ[i + 1] != testQ[i]) begin
        reportTest(testQ[i]);
      end
    end

    do begin
      @(negedge clk);
      checkCount++;
      if (wbEn) begin
        flagError($sformatf("write-back R%0d = %h after the last expected row", wbAddr, wbData));
      end
    end while (!hlt);
    pcAtHalt = pc;
    checkCount++;
    if (pcAtHalt !== word_t'(hltRow + 1)) begin     // Frozen one past HLT
      flagError($sformatf("pc %h at hlt, expected %h", pcAtHalt, word_t'(hltRow + 1)));
    end
    repeat (HaltWatch) begin
      @(negedge clk);
      checkCount++;
      if (wbEn || !hlt || pc !== pcAtHalt) begin
        flagError($sformatf("after hlt: wbEn %b hlt %b pc %h", wbEn, hlt, pc));
      end
    end
    reportTest("halt");

    $display("checks: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog, two cycles per row plus margin
  initial begin
    @(posedge rstN);
    repeat (progQ.size() * 2 + 20) @(posedge clk);
    $display("timeout: program did not finish within %0d cycles after reset",
             progQ.size() * 2 + 20);
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- pipeCpu.f
+incdir+rtl
rtl/pipeCpuPkg.sv
rtl/regFile.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/pipeCpu.sv
verification/pipeCpu_properties.sv
verification/pipeCpuTb.sv

//--- run.sh
#!/bin/sh
# Build the pipeCpu testbench with Verilator, run it, then judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module pipeCpuTb \
  -f pipeCpu.f --Mdir obj_dir -o pipeCpuSim

# A failed assertion stops the binary early, so judge the log and not the exit code
./obj_dir/pipeCpuSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log || ! grep -q "Done: no errors" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"
